/* verilog/exe_consts.svh */
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// datapath widths
`define EXE_XLEN     32
`define EXE_REG_W    5
`define EXE_HALF_W   16
`define EXE_LINK_OFS 4

// instruction class codes
`define EXE_IT_ALU   2'd0
`define EXE_IT_MUL   2'd1
`define EXE_IT_BR    2'd2

// alu operation codes
`define EXE_ALU_ADD  4'd0
`define EXE_ALU_SUB  4'd1
`define EXE_ALU_SLT  4'd2
`define EXE_ALU_SLTU 4'd3
`define EXE_ALU_AND  4'd4
`define EXE_ALU_OR   4'd5
`define EXE_ALU_XOR  4'd6
`define EXE_ALU_NOR  4'd7
`define EXE_ALU_SLL  4'd8
`define EXE_ALU_SRL  4'd9
`define EXE_ALU_SRA  4'd10
`define EXE_ALU_LUI  4'd11

// branch condition codes
`define EXE_BR_JIRL  4'd3
`define EXE_BR_B     4'd4
`define EXE_BR_BL    4'd5
`define EXE_BR_BEQ   4'd6
`define EXE_BR_BNE   4'd7
`define EXE_BR_BLT   4'd8
`define EXE_BR_BGE   4'd9
`define EXE_BR_BLTU  4'd10
`define EXE_BR_BGEU  4'd11

`endif

/* verilog/exe_uop_pkg.sv */
`include "exe_consts.svh"

package exe_uop_pkg;

    typedef enum logic [1:0] {
        IT_ALU = `EXE_IT_ALU,
        IT_MUL = `EXE_IT_MUL,
        IT_BR  = `EXE_IT_BR
    } itype_t;

    typedef enum logic [3:0] {
        ALU_ADD  = `EXE_ALU_ADD,
        ALU_SUB  = `EXE_ALU_SUB,
        ALU_SLT  = `EXE_ALU_SLT,
        ALU_SLTU = `EXE_ALU_SLTU,
        ALU_AND  = `EXE_ALU_AND,
        ALU_OR   = `EXE_ALU_OR,
        ALU_XOR  = `EXE_ALU_XOR,
        ALU_NOR  = `EXE_ALU_NOR,
        ALU_SLL  = `EXE_ALU_SLL,
        ALU_SRL  = `EXE_ALU_SRL,
        ALU_SRA  = `EXE_ALU_SRA,
        ALU_LUI  = `EXE_ALU_LUI
    } alu_op_t;

    typedef enum logic [3:0] {
        BR_JIRL = `EXE_BR_JIRL,
        BR_B    = `EXE_BR_B,
        BR_BL   = `EXE_BR_BL,
        BR_BEQ  = `EXE_BR_BEQ,
        BR_BNE  = `EXE_BR_BNE,
        BR_BLT  = `EXE_BR_BLT,
        BR_BGE  = `EXE_BR_BGE,
        BR_BLTU = `EXE_BR_BLTU,
        BR_BGEU = `EXE_BR_BGEU
    } br_cond_t;

    typedef struct packed {
        itype_t   itype;
        alu_op_t  alu_op;
        br_cond_t br_cond;
        logic     src2_imm;
        logic     mul_high;
        logic     mul_signed;
    } uop_t;

endpackage

/* verilog/exe_pipe_pkg.sv */
`include "exe_consts.svh"

package exe_pipe_pkg;
    import exe_uop_pkg::*;

    // one lane as offered by issue
    typedef struct packed {
        logic                  valid;
        uop_t                  uop;
        logic [`EXE_REG_W-1:0] rd;
        logic [`EXE_REG_W-1:0] rj;
        logic [`EXE_REG_W-1:0] rk;
        logic [`EXE_XLEN-1:0]  imm;
        logic [`EXE_XLEN-1:0]  pc;
        logic [`EXE_XLEN-1:0]  pc_next;
    } issue_t;

    typedef struct packed {
        logic [`EXE_XLEN-1:0] rj_data;
        logic [`EXE_XLEN-1:0] rk_data;
    } operands_t;

    typedef struct packed {
        logic                  en;
        logic [`EXE_REG_W-1:0] rd;
        logic [`EXE_XLEN-1:0]  data;
        logic [`EXE_XLEN-1:0]  pc;
    } wb_t;

    typedef struct packed {
        logic                 redirect;
        logic                 taken;
        logic [`EXE_XLEN-1:0] target;
    } br_res_t;

    // multiplier state between its two steps
    typedef struct packed {
        logic [`EXE_XLEN-1:0]  pp_hh;
        logic [`EXE_XLEN-1:0]  pp_hl;
        logic [`EXE_XLEN-1:0]  pp_lh;
        logic [`EXE_XLEN-1:0]  pp_ll;
        logic [`EXE_XLEN-1:0]  adj;
        logic                  mul_high;
        logic [`EXE_REG_W-1:0] rd;
    } mul_part_t;

endpackage

/* verilog/exe_alu.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_alu (
    input  exe_uop_pkg::alu_op_t op,
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    input  logic [`EXE_XLEN-1:0] imm,
    output logic [`EXE_XLEN-1:0] result
);
    import exe_uop_pkg::*;

    localparam int SH_W = $clog2(`EXE_XLEN);

    logic [SH_W-1:0] sh;
    logic            lt_s;
    logic            lt_u;

    always_comb begin
        sh = b[SH_W-1:0];
        lt_s = $signed(a) < $signed(b);
        lt_u = a < b;
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLT:  result = {{(`EXE_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result = {{(`EXE_XLEN-1){1'b0}}, lt_u};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLL:  result = a << sh;
            ALU_SRL:  result = a >> sh;
            ALU_SRA:  result = $unsigned($signed(a) >>> sh);
            // immediate already shifted by decode
            ALU_LUI:  result = imm;
            default:  result = '0;
        endcase
    end

endmodule

/* verilog/exe_branch.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_branch (
    input  exe_uop_pkg::br_cond_t  cond,
    input  logic [`EXE_XLEN-1:0]   pc,
    input  logic [`EXE_XLEN-1:0]   pc_next,
    input  logic [`EXE_XLEN-1:0]   imm,
    input  logic [`EXE_XLEN-1:0]   rj_val,
    input  logic [`EXE_XLEN-1:0]   rk_val,
    output exe_pipe_pkg::br_res_t  res,
    output logic [`EXE_XLEN-1:0]   link
);
    import exe_uop_pkg::*;

    logic                 eq;
    logic                 lt_s;
    logic                 lt_u;
    logic                 taken;
    logic [`EXE_XLEN-1:0] target;
    logic [`EXE_XLEN-1:0] seq_pc;
    logic [`EXE_XLEN-1:0] actual_pc;

    always_comb begin
        eq = rj_val == rk_val;
        lt_s = $signed(rj_val) < $signed(rk_val);
        lt_u = rj_val < rk_val;
        case (cond)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            BR_B,
            BR_BL,
            BR_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase

        // jirl is register relative, the rest pc relative
        target = (cond == BR_JIRL) ? rj_val + imm : pc + imm;
        seq_pc = pc + `EXE_LINK_OFS;
        actual_pc = taken ? target : seq_pc;

        // mispredicted when fetch went elsewhere
        res.redirect = actual_pc != pc_next;
        res.taken = taken;
        res.target = target;
        link = seq_pc;
    end

endmodule

/* verilog/exe_mul.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_mul (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  logic                  hold,
    input  logic                  clear,
    input  logic [`EXE_XLEN-1:0]  a,
    input  logic [`EXE_XLEN-1:0]  b,
    input  logic                  is_signed,
    input  logic                  high,
    input  logic [`EXE_REG_W-1:0] rd,
    output logic [`EXE_REG_W-1:0] part_rd,
    output logic [`EXE_XLEN-1:0]  result
);
    import exe_pipe_pkg::*;

    localparam int H = `EXE_HALF_W;
    localparam int W = `EXE_XLEN;

    mul_part_t      part_d;
    mul_part_t      part_q;
    logic [H-1:0]   a_lo;
    logic [H-1:0]   a_hi;
    logic [H-1:0]   b_lo;
    logic [H-1:0]   b_hi;
    logic [2*W-1:0] prod;

    // step 1: unsigned 16x16 partial products
    always_comb begin
        a_lo = a[H-1:0];
        a_hi = a[W-1:H];
        b_lo = b[H-1:0];
        b_hi = b[W-1:H];
        part_d.pp_ll = W'(a_lo) * W'(b_lo);
        part_d.pp_lh = W'(a_lo) * W'(b_hi);
        part_d.pp_hl = W'(a_hi) * W'(b_lo);
        part_d.pp_hh = W'(a_hi) * W'(b_hi);
        // signed operands subtract the other operand from the upper word
        part_d.adj = '0;
        if (is_signed) begin
            if (a[W-1]) begin
                part_d.adj = part_d.adj - b;
            end
            if (b[W-1]) begin
                part_d.adj = part_d.adj - a;
            end
        end
        part_d.mul_high = high;
        part_d.rd = rd;
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            part_q <= '0;
        end else if (load && !hold) begin
            part_q <= part_d;
        end
    end

    // step 2: sum the partials
    always_comb begin
        prod = {part_q.pp_hh, part_q.pp_ll}
             + ({{W{1'b0}}, part_q.pp_lh} << H)
             + ({{W{1'b0}}, part_q.pp_hl} << H)
             + {part_q.adj, {W{1'b0}}};
        result = part_q.mul_high ? prod[2*W-1:W] : prod[W-1:0];
    end

    assign part_rd = part_q.rd;

endmodule

/* verilog/exe_bypass.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_bypass (
    input  exe_pipe_pkg::issue_t    in0,
    input  exe_pipe_pkg::issue_t    in1,
    input  exe_pipe_pkg::operands_t rf0,
    input  exe_pipe_pkg::operands_t rf1,
    input  exe_pipe_pkg::wb_t       x0,
    input  exe_pipe_pkg::wb_t       x1,
    input  exe_pipe_pkg::wb_t       w0,
    input  exe_pipe_pkg::wb_t       w1,
    input  logic                    mul_busy,
    input  logic [`EXE_REG_W-1:0]   mul_rd,
    output exe_pipe_pkg::operands_t op0,
    output exe_pipe_pkg::operands_t op1,
    output logic                    stall
);
    import exe_pipe_pkg::*;

    function automatic logic hit(input wb_t p, input logic [`EXE_REG_W-1:0] src);
        return p.en && (p.rd == src);
    endfunction

    // youngest producer first: exe1 lane 1, exe1 lane 0, wb lane 1, wb lane 0
    function automatic logic [`EXE_XLEN-1:0] fwd(
        input logic [`EXE_REG_W-1:0] src,
        input logic [`EXE_XLEN-1:0]  rf_val
    );
        logic [`EXE_XLEN-1:0] v;
        v = rf_val;
        if (src != '0) begin
            if (hit(x1, src)) begin
                v = x1.data;
            end else if (hit(x0, src)) begin
                v = x0.data;
            end else if (hit(w1, src)) begin
                v = w1.data;
            end else if (hit(w0, src)) begin
                v = w0.data;
            end
        end
        return v;
    endfunction

    function automatic logic reads(input issue_t in, input logic [`EXE_REG_W-1:0] r);
        return in.valid && ((in.rj == r) || (in.rk == r));
    endfunction

    always_comb begin
        op0.rj_data = fwd(in0.rj, rf0.rj_data);
        op0.rk_data = fwd(in0.rk, rf0.rk_data);
        op1.rj_data = fwd(in1.rj, rf1.rj_data);
        op1.rk_data = fwd(in1.rk, rf1.rk_data);
    end

    // product is not ready until it leaves exe1
    assign stall = mul_busy && (mul_rd != '0) && (reads(in0, mul_rd) || reads(in1, mul_rd));

endmodule

/* verilog/exe_stage.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module exe_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    output logic                    issue_ready,
    input  exe_pipe_pkg::issue_t    issue0,
    input  exe_pipe_pkg::issue_t    issue1,
    input  exe_pipe_pkg::operands_t rf0,
    input  exe_pipe_pkg::operands_t rf1,
    output exe_pipe_pkg::wb_t       wb0,
    output exe_pipe_pkg::wb_t       wb1,
    output exe_pipe_pkg::br_res_t   br_res
);
    import exe_uop_pkg::*;
    import exe_pipe_pkg::*;

    operands_t             op0;
    operands_t             op1;
    logic                  stall;
    logic                  fire;
    logic                  kill;
    logic                  take;
    logic                  lane0_mul;
    logic                  lane0_br;
    logic                  link_wr;
    logic [`EXE_XLEN-1:0]  alu0_b;
    logic [`EXE_XLEN-1:0]  alu1_b;
    logic [`EXE_XLEN-1:0]  alu0_res;
    logic [`EXE_XLEN-1:0]  alu1_res;
    logic [`EXE_XLEN-1:0]  link;
    br_res_t               br_out;
    wb_t                   x0_d;
    wb_t                   x1_d;
    wb_t                   x0;
    wb_t                   x1;
    logic                  mul_pend;
    logic [`EXE_XLEN-1:0]  mul_pc;
    logic [`EXE_REG_W-1:0] mul_rd;
    logic [`EXE_XLEN-1:0]  mul_res;

    assign issue_ready = !stall;
    assign fire = issue_valid && issue_ready;
    // a redirect drops whatever is handshaken in its cycle
    assign kill = br_res.redirect;
    assign take = fire && !kill;

    assign lane0_mul = issue0.valid && (issue0.uop.itype == IT_MUL);
    assign lane0_br = issue0.valid && (issue0.uop.itype == IT_BR);
    assign link_wr = lane0_br
                     && ((issue0.uop.br_cond == BR_BL) || (issue0.uop.br_cond == BR_JIRL));

    assign alu0_b = issue0.uop.src2_imm ? issue0.imm : op0.rk_data;
    assign alu1_b = issue1.uop.src2_imm ? issue1.imm : op1.rk_data;

    exe_bypass i_exe_bypass (
        .in0      (issue0),
        .in1      (issue1),
        .rf0      (rf0),
        .rf1      (rf1),
        .x0       (x0),
        .x1       (x1),
        .w0       (wb0),
        .w1       (wb1),
        .mul_busy (mul_pend),
        .mul_rd   (mul_rd),
        .op0      (op0),
        .op1      (op1),
        .stall    (stall)
    );

    exe_alu i_exe_alu0 (
        .op     (issue0.uop.alu_op),
        .a      (op0.rj_data),
        .b      (alu0_b),
        .imm    (issue0.imm),
        .result (alu0_res)
    );

    exe_alu i_exe_alu1 (
        .op     (issue1.uop.alu_op),
        .a      (op1.rj_data),
        .b      (alu1_b),
        .imm    (issue1.imm),
        .result (alu1_res)
    );

    exe_branch i_exe_branch (
        .cond    (issue0.uop.br_cond),
        .pc      (issue0.pc),
        .pc_next (issue0.pc_next),
        .imm     (issue0.imm),
        .rj_val  (op0.rj_data),
        .rk_val  (op0.rk_data),
        .res     (br_out),
        .link    (link)
    );

    exe_mul i_exe_mul (
        .clk       (clk),
        .rst       (rst),
        .load      (issue_valid && lane0_mul),
        .hold      (!issue_ready),
        .clear     (kill),
        .a         (op0.rj_data),
        .b         (op0.rk_data),
        .is_signed (issue0.uop.mul_signed),
        .high      (issue0.uop.mul_high),
        .rd        (issue0.rd),
        .part_rd   (mul_rd),
        .result    (mul_res)
    );

    always_comb begin
        x0_d.en = take && issue0.valid && ((issue0.uop.itype == IT_ALU) || link_wr);
        x0_d.rd = issue0.rd;
        x0_d.data = lane0_br ? link : alu0_res;
        x0_d.pc = issue0.pc;
        x1_d.en = take && issue1.valid;
        x1_d.rd = issue1.rd;
        x1_d.data = alu1_res;
        x1_d.pc = issue1.pc;
    end

    // exe1 registers
    always_ff @(posedge clk) begin
        x0 <= x0_d;
        x1 <= x1_d;
        if (fire && lane0_mul) begin
            mul_pc <= issue0.pc;
        end
        if (rst) begin
            x0.en <= 1'b0;
            x1.en <= 1'b0;
            mul_pend <= 1'b0;
            br_res <= '0;
        end else begin
            mul_pend <= take && lane0_mul;
            br_res <= (take && lane0_br) ? br_out : '0;
        end
    end

    // writeback registers, lane 0 shared with the multiplier
    always_ff @(posedge clk) begin
        if (mul_pend) begin
            wb0.rd <= mul_rd;
            wb0.data <= mul_res;
            wb0.pc <= mul_pc;
        end else begin
            wb0.rd <= x0.rd;
            wb0.data <= x0.data;
            wb0.pc <= x0.pc;
        end
        wb1.rd <= x1.rd;
        wb1.data <= x1.data;
        wb1.pc <= x1.pc;
        if (rst) begin
            wb0.en <= 1'b0;
            wb1.en <= 1'b0;
        end else begin
            wb0.en <= x0.en || mul_pend;
            // younger lane of a mispredicted branch bundle
            wb1.en <= x1.en && !kill;
        end
    end

endmodule

/* sim/tb_exe_stage.sv */
`timescale 1ns/1ps
`include "exe_consts.svh"

module tb_exe_stage;
    import exe_uop_pkg::*;
    import exe_pipe_pkg::*;

    localparam int TIMEOUT = 20;

    logic      clk;
    logic      rst;
    logic      issue_valid;
    logic      issue_ready;
    issue_t    issue0;
    issue_t    issue1;
    operands_t rf0;
    operands_t rf1;
    wb_t       wb0;
    wb_t       wb1;
    br_res_t   br_res;

    wb_t         q0[$];
    wb_t         q1[$];
    logic [31:0] regs [0:31];
    integer      seed;
    int          errors;
    int          tests;
    int          err_start;

    exe_stage i_exe_stage (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue0      (issue0),
        .issue1      (issue1),
        .rf0         (rf0),
        .rf1         (rf1),
        .wb0         (wb0),
        .wb1         (wb1),
        .br_res      (br_res)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // collect every writeback in order
    always @(negedge clk) begin
        if (!rst && wb0.en) q0.push_back(wb0);
        if (!rst && wb1.en) q1.push_back(wb1);
    end

    function automatic issue_t alu_uop(input alu_op_t op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk,
                                       input logic sel, input logic [31:0] imm);
        issue_t u;
        u = '0;
        u.valid = 1'b1;
        u.uop.itype = IT_ALU;
        u.uop.alu_op = op;
        u.uop.src2_imm = sel;
        u.rd = rd;
        u.rj = rj;
        u.rk = rk;
        u.imm = imm;
        u.pc = 32'h100 + {25'b0, rd, 2'b0};
        u.pc_next = u.pc + 32'd4;
        return u;
    endfunction

    function automatic wb_t mk_wb(input logic [4:0] rd, input logic [31:0] data,
                                  input logic [31:0] pc);
        wb_t w;
        w.en = 1'b1;
        w.rd = rd;
        w.data = data;
        w.pc = pc;
        return w;
    endfunction

    // operation table
    function automatic logic [31:0] alu_model(input alu_op_t op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [31:0] imm);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return 32'($signed(a) >>> b[4:0]);
            ALU_LUI:  return imm;
            default:  return 32'h0;
        endcase
    endfunction

    function automatic logic taken_model(input br_cond_t c, input logic [31:0] a,
                                         input logic [31:0] b);
        case (c)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    task automatic check_wb(input wb_t got, input wb_t exp, input string name);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_br(input br_res_t got, input br_res_t exp, input string name);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic offer(input issue_t b0, input issue_t b1, input operands_t r0,
                         input operands_t r1);
        @(negedge clk);
        issue_valid = 1'b1;
        issue0 = b0;
        issue1 = b1;
        rf0 = r0;
        rf1 = r1;
    endtask

    task automatic idle();
        @(negedge clk);
        issue_valid = 1'b0;
        issue0 = '0;
        issue1 = '0;
    endtask

    // nothing one cycle after acceptance, the result one cycle later
    task automatic verify_latency(input int n0, input int n1, input string name);
        logic early;
        #1;
        early = (q0.size() != 0) || (q1.size() != 0);
        @(negedge clk);
        #1;
        if (early || q0.size() != n0 || q1.size() != n1) begin
            $display("%s result not written back two cycles after acceptance", name);
            errors++;
        end
    endtask

    task automatic expect_wb(input int lane, input wb_t exp, input string name);
        int  cnt;
        wb_t got;
        cnt = 0;
        while (((lane == 0) ? q0.size() : q1.size()) == 0 && cnt < TIMEOUT) begin
            @(negedge clk);
            #1;
            cnt++;
        end
        if (((lane == 0) ? q0.size() : q1.size()) == 0) begin
            $display("timeout while waiting for %s to be written back", name);
            errors++;
        end else begin
            got = (lane == 0) ? q0.pop_front() : q1.pop_front();
            check_wb(got, exp, name);
        end
    endtask

    task automatic start_test();
        err_start = errors;
        q0.delete();
        q1.delete();
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: %0d errors", name, errors - err_start);
    endtask

    task automatic test_dual_alu();
        issue_t      b0;
        issue_t      b1;
        operands_t   r0;
        operands_t   r1;
        logic [31:0] rnd;
        logic [31:0] imm0;
        logic [31:0] imm1;
        start_test();
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            imm0 = $random(seed);
            imm1 = $random(seed);
            r0.rj_data = $random(seed);
            r0.rk_data = $random(seed);
            r1.rj_data = $random(seed);
            r1.rk_data = $random(seed);
            b0 = alu_uop(alu_op_t'(k % 12), 5'd10, 5'd1, 5'd2, rnd[0], imm0);
            b1 = alu_uop(alu_op_t'(11 - (k % 12)), 5'd11, 5'd3, 5'd4, rnd[1], imm1);
            offer(b0, b1, r0, r1);
            idle();
            verify_latency(1, 1, "alu");
            expect_wb(0, mk_wb(5'd10, alu_model(b0.uop.alu_op, r0.rj_data,
                      rnd[0] ? imm0 : r0.rk_data, imm0), b0.pc), "wb0");
            expect_wb(1, mk_wb(5'd11, alu_model(b1.uop.alu_op, r1.rj_data,
                      rnd[1] ? imm1 : r1.rk_data, imm1), b1.pc), "wb1");
        end
        end_test("dual alu");
    endtask

    task automatic test_multiply();
        logic [31:0] av [0:5];
        logic [31:0] bv [0:5];
        logic [63:0] p;
        issue_t      m;
        operands_t   r;
        start_test();
        av[0] = 32'h8000_0000;
        bv[0] = 32'h8000_0000;
        av[1] = 32'hFFFF_FFFF;
        bv[1] = 32'h7FFF_FFFF;
        av[2] = 32'h7FFF_FFFF;
        bv[2] = 32'h7FFF_FFFF;
        av[3] = 32'hFFFF_FFFF;
        bv[3] = 32'hFFFF_FFFF;
        av[4] = $random(seed);
        bv[4] = $random(seed);
        av[5] = $random(seed);
        bv[5] = 32'h8000_0001;
        // every operand pair with all four signed and high combinations
        for (int i = 0; i < 24; i++) begin
            m = alu_uop(ALU_ADD, 5'd5, 5'd3, 5'd4, 1'b0, 32'h0);
            m.uop.itype = IT_MUL;
            m.uop.mul_signed = i[0];
            m.uop.mul_high = i[1];
            r.rj_data = av[i / 4];
            r.rk_data = bv[i / 4];
            if (i[0]) begin
                p = 64'($signed({{32{r.rj_data[31]}}, r.rj_data})
                        * $signed({{32{r.rk_data[31]}}, r.rk_data}));
            end else begin
                p = {32'b0, r.rj_data} * {32'b0, r.rk_data};
            end
            offer(m, '0, r, '0);
            idle();
            verify_latency(1, 0, "multiply");
            expect_wb(0, mk_wb(5'd5, i[1] ? p[63:32] : p[31:0], m.pc), "wb0");
        end
        end_test("multiply");
    endtask

    task automatic test_forwarding();
        issue_t    a0;
        issue_t    a1;
        issue_t    b0;
        issue_t    b1;
        issue_t    c0;
        issue_t    c1;
        operands_t r0;
        operands_t r1;
        operands_t stale;
        wb_t       e0 [0:2];
        wb_t       e1 [0:2];
        start_test();
        for (int i = 1; i < 32; i++) begin
            regs[i] = $random(seed);
        end
        stale.rj_data = 32'hBAD0_0001;
        stale.rk_data = 32'hBAD0_0002;
        a0 = alu_uop(ALU_ADD, 5'd10, 5'd1, 5'd2, 1'b0, 32'h0);
        a1 = alu_uop(ALU_XOR, 5'd11, 5'd3, 5'd4, 1'b0, 32'h0);
        // within lane, across lanes, and r10 redefined by the younger lane
        b0 = alu_uop(ALU_SUB, 5'd12, 5'd11, 5'd10, 1'b0, 32'h0);
        b1 = alu_uop(ALU_AND, 5'd10, 5'd10, 5'd11, 1'b0, 32'h0);
        c0 = alu_uop(ALU_ADD, 5'd14, 5'd10, 5'd12, 1'b0, 32'h0);
        c1 = alu_uop(ALU_NOR, 5'd15, 5'd11, 5'd12, 1'b0, 32'h0);
        r0.rj_data = regs[1];
        r0.rk_data = regs[2];
        r1.rj_data = regs[3];
        r1.rk_data = regs[4];
        regs[10] = regs[1] + regs[2];
        regs[11] = regs[3] ^ regs[4];
        e0[0] = mk_wb(5'd10, regs[10], a0.pc);
        e1[0] = mk_wb(5'd11, regs[11], a1.pc);
        regs[12] = regs[11] - regs[10];
        regs[10] = regs[10] & regs[11];
        e0[1] = mk_wb(5'd12, regs[12], b0.pc);
        e1[1] = mk_wb(5'd10, regs[10], b1.pc);
        regs[14] = regs[10] + regs[12];
        regs[15] = ~(regs[11] | regs[12]);
        e0[2] = mk_wb(5'd14, regs[14], c0.pc);
        e1[2] = mk_wb(5'd15, regs[15], c1.pc);
        offer(a0, a1, r0, r1);
        offer(b0, b1, stale, stale);
        offer(c0, c1, stale, stale);
        idle();
        for (int i = 0; i < 3; i++) begin
            expect_wb(0, e0[i], "wb0");
            expect_wb(1, e1[i], "wb1");
        end
        end_test("forwarding");
    endtask

    task automatic test_interlock();
        issue_t      m;
        issue_t      u;
        operands_t   r;
        operands_t   ru;
        logic [31:0] p;
        int          cnt;
        logic        stalled;
        start_test();
        m = alu_uop(ALU_ADD, 5'd5, 5'd3, 5'd4, 1'b0, 32'h0);
        m.uop.itype = IT_MUL;
        m.uop.mul_signed = 1'b1;
        u = alu_uop(ALU_ADD, 5'd6, 5'd5, 5'd2, 1'b0, 32'h0);
        r.rj_data = $random(seed);
        r.rk_data = $random(seed);
        ru.rj_data = 32'hBAD0_0005;
        ru.rk_data = $random(seed);
        p = r.rj_data * r.rk_data;
        offer(m, '0, r, '0);
        offer(u, '0, ru, '0);
        #1;
        cnt = 0;
        stalled = 1'b0;
        while (!issue_ready && cnt < TIMEOUT) begin
            stalled = 1'b1;
            @(negedge clk);
            #1;
            cnt++;
        end
        if (!stalled) begin
            $display("issue_ready never dropped behind the multiply");
            errors++;
        end
        if (!issue_ready) begin
            $display("timeout while waiting for issue_ready to return");
            errors++;
        end
        idle();
        expect_wb(0, mk_wb(5'd5, p, m.pc), "wb0");
        expect_wb(0, mk_wb(5'd6, p + ru.rk_data, u.pc), "wb0");
        end_test("interlock");
    endtask

    task automatic test_branches();
        logic [31:0] av [0:2];
        logic [31:0] bv [0:2];
        br_cond_t    c;
        issue_t      br;
        issue_t      f0;
        issue_t      f1;
        issue_t      y1;
        operands_t   r;
        br_res_t     exp;
        logic [31:0] actual;
        logic        link;
        start_test();
        av[0] = 32'd5;
        bv[0] = 32'd5;
        av[1] = 32'hFFFF_FFFD;
        bv[1] = 32'd4;
        av[2] = 32'd4;
        bv[2] = 32'hFFFF_FFFD;
        y1 = alu_uop(ALU_ADD, 5'd7, 5'd3, 5'd4, 1'b0, 32'h0);
        f0 = alu_uop(ALU_ADD, 5'd9, 5'd3, 5'd4, 1'b0, 32'h0);
        f1 = alu_uop(ALU_ADD, 5'd13, 5'd3, 5'd4, 1'b0, 32'h0);
        for (int k = 3; k < 12; k++) begin
            for (int i = 0; i < 6; i++) begin
                c = br_cond_t'(k);
                br = alu_uop(ALU_ADD, 5'd12, 5'd1, 5'd2, 1'b0, 32'h40 + 32'(i * 8));
                br.uop.itype = IT_BR;
                br.uop.br_cond = c;
                br.pc = 32'h2000 + 32'(k * 64);
                r.rj_data = av[i / 2];
                r.rk_data = bv[i / 2];
                exp.taken = taken_model(c, r.rj_data, r.rk_data);
                exp.target = (c == BR_JIRL) ? r.rj_data + br.imm : br.pc + br.imm;
                actual = exp.taken ? exp.target : br.pc + 32'd4;
                exp.redirect = i[0];
                br.pc_next = i[0] ? actual + 32'd8 : actual;
                link = (c == BR_BL) || (c == BR_JIRL);
                q0.delete();
                q1.delete();
                offer(br, y1, r, r);
                offer(f0, f1, r, r);
                #1;
                check_br(br_res, exp, "br_res");
                idle();
                #1;
                // redirect lasts a single cycle
                check_br(br_res, '0, "br_res");
                repeat (3) @(negedge clk);
                #1;
                if (link) begin
                    expect_wb(0, mk_wb(5'd12, br.pc + 32'd4, br.pc), "wb0 link");
                end
                if (i[0] && (q0.size() != 0 || q1.size() != 0)) begin
                    $display("killed instruction reached writeback after redirect");
                    errors++;
                end
                if (!i[0] && (q0.size() != 1 || q1.size() != 2)) begin
                    $display("instructions missing from writeback without redirect");
                    errors++;
                end
            end
        end
        end_test("branches");
    endtask

    initial begin
        seed = 81016;
        errors = 0;
        tests = 0;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue0 = '0;
        issue1 = '0;
        rf0 = '0;
        rf1 = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        if (wb0.en || wb1.en || br_res.redirect || !issue_ready) begin
            $display("outputs not idle after reset");
            errors++;
        end
        test_dual_alu();
        test_multiply();
        test_forwarding();
        test_interlock();
        test_branches();
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/exe_uop_pkg.sv
verilog/exe_pipe_pkg.sv
verilog/exe_alu.sv
verilog/exe_branch.sv
verilog/exe_mul.sv
verilog/exe_bypass.sv
verilog/exe_stage.sv
sim/tb_exe_stage.sv

/* run_sim.sh */
#!/bin/bash
# build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_exe_stage -f verilog.f \
    -o tb_exe_stage > build.log 2>&1 \
    && ./obj_dir/tb_exe_stage > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1
